// ==== verilog/svfPkg.sv ====
`default_nettype none

package svfPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data types

  typedef logic signed [17:0] sampleT;  // Audio sample
  typedef logic signed [17:0] coefT;    // Coefficient, 17 fraction bits
  typedef logic signed [35:0] accT;     // Filter state or product
  typedef logic [7:0]         addrT;    // AXI byte address
  typedef logic [31:0]        dataT;    // AXI data word

  ////////////////////////////////////////////////////////////////////////////
  // Fixed-point scaling

  localparam int COEF_FRAC    = 17;  // Fraction bits of f, q and gains
  localparam int SAMPLE_SHIFT = 18;  // Input sample to filter state scale

  localparam sampleT SAMPLE_MAX = 18'sh1FFFF;  // +131071
  localparam sampleT SAMPLE_MIN = 18'sh20000;  // -131072

  ////////////////////////////////////////////////////////////////////////////
  // Register map

  localparam addrT ADDR_FA     = 8'h00;  // Voice A frequency
  localparam addrT ADDR_QA     = 8'h04;  // Voice A damping
  localparam addrT ADDR_FB     = 8'h08;  // Voice B frequency
  localparam addrT ADDR_QB     = 8'h0C;  // Voice B damping
  localparam addrT ADDR_GAIN_A = 8'h10;
  localparam addrT ADDR_GAIN_B = 8'h14;
  localparam addrT ADDR_STATUS = 8'h18;  // Mixed sample count, read only

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Core sequence, one multiply per state
  typedef enum logic [1:0] {IDLE, DAMP, INTEG1, INTEG2} coreStateE;

endpackage

`default_nettype wire

// ==== verilog/svfRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module svfRegs import svfPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  // AXI4-Lite write channels
  input  logic       sAwvalid,
  output logic       sAwready,
  input  addrT       sAwaddr,
  input  logic       sWvalid,
  output logic       sWready,
  input  dataT       sWdata,
  output logic       sBvalid,
  input  logic       sBready,
  output logic [1:0] sBresp,
  // AXI4-Lite read channels
  input  logic       sArvalid,
  output logic       sArready,
  input  addrT       sAraddr,
  output logic       sRvalid,
  input  logic       sRready,
  output dataT       sRdata,
  output logic [1:0] sRresp,
  // Mixer strobe for the sample counter
  input  logic       outValid,
  // Coefficients
  output coefT       fA,
  output coefT       qA,
  output coefT       fB,
  output coefT       qB,
  output coefT       gainA,
  output coefT       gainB
);

  logic       awHeld, wHeld;      // One half of a write already taken
  addrT       awAddrReg;
  dataT       wDataReg;
  logic       awFire, wFire, arFire;
  logic       wrGo;               // Both halves present this cycle
  addrT       wrAddr;
  dataT       wrData;
  logic [1:0] wrResp, rdResp;
  dataT       rdWord;
  dataT       sampleCount;        // Mixed samples since reset

  function automatic dataT signExt(input coefT c);
    return {{14{c[17]}}, c};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Write path

  assign sAwready = !awHeld && !sBvalid;  // Stall while a response waits
  assign sWready  = !wHeld && !sBvalid;
  assign awFire   = sAwvalid && sAwready;
  assign wFire    = sWvalid && sWready;
  assign wrGo     = (awHeld || awFire) && (wHeld || wFire);
  assign wrAddr   = awHeld ? awAddrReg : sAwaddr;  // Held or live address
  assign wrData   = wHeld ? wDataReg : sWdata;

  // Only the coefficient words are writable
  always_comb
  begin
    case (wrAddr)
      ADDR_FA, ADDR_QA, ADDR_FB, ADDR_QB, ADDR_GAIN_A, ADDR_GAIN_B:
        wrResp = RESP_OKAY;
      default:
        wrResp = RESP_SLVERR;  // STATUS and holes
    endcase
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      awHeld  <= 1'b0;
      wHeld   <= 1'b0;
      sBvalid <= 1'b0;
      fA      <= '0;
      qA      <= '0;
      fB      <= '0;
      qB      <= '0;
      gainA   <= '0;
      gainB   <= '0;
    end
    else
    begin
      if (wrGo)
      begin
        awHeld  <= 1'b0;
        wHeld   <= 1'b0;
        sBvalid <= 1'b1;            // Response in the next cycle
        if (wrResp == RESP_OKAY)
        begin
          case (wrAddr)
            ADDR_FA:     fA    <= wrData[17:0];  // Upper bits dropped
            ADDR_QA:     qA    <= wrData[17:0];
            ADDR_FB:     fB    <= wrData[17:0];
            ADDR_QB:     qB    <= wrData[17:0];
            ADDR_GAIN_A: gainA <= wrData[17:0];
            default:     gainB <= wrData[17:0];
          endcase
        end
      end
      else
      begin
        if (awFire)
          awHeld <= 1'b1;           // Wait for the data
        if (wFire)
          wHeld <= 1'b1;            // Wait for the address
        if (sBvalid && sBready)
          sBvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (awFire)
      awAddrReg <= sAwaddr;
    if (wFire)
      wDataReg <= sWdata;
    if (wrGo)
      sBresp <= wrResp;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read path

  assign sArready = !sRvalid;  // One read outstanding
  assign arFire   = sArvalid && sArready;

  always_comb
  begin
    rdWord = '0;
    rdResp = RESP_OKAY;
    case (sAraddr)
      ADDR_FA:     rdWord = signExt(fA);
      ADDR_QA:     rdWord = signExt(qA);
      ADDR_FB:     rdWord = signExt(fB);
      ADDR_QB:     rdWord = signExt(qB);
      ADDR_GAIN_A: rdWord = signExt(gainA);
      ADDR_GAIN_B: rdWord = signExt(gainB);
      ADDR_STATUS: rdWord = sampleCount;
      default:     rdResp = RESP_SLVERR;  // Data stays zero
    endcase
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      sRvalid     <= 1'b0;
      sampleCount <= '0;
    end
    else
    begin
      if (arFire)
        sRvalid <= 1'b1;
      else if (sRready)
        sRvalid <= 1'b0;
      if (outValid)
        sampleCount <= sampleCount + 32'd1;  // One per mixed sample
    end
  end

  always_ff @(posedge clk)
  begin
    if (arFire)
    begin
      sRdata <= rdWord;
      sRresp <= rdResp;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/svfCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module svfCore import svfPkg::*;
(
  input  logic   clk,
  input  logic   rstN,
  input  logic   start,     // Accepted sample strobe
  input  sampleT sampleIn,
  input  coefT   f,         // Frequency coefficient
  input  coefT   q,         // Damping, 1/Q
  output sampleT yOut,      // Low-pass output
  output logic   done,      // One cycle, four after start
  output logic   busy
);

  coreStateE state;
  sampleT    xLatch;        // Sample held for the DAMP step
  coefT      mA, mB;        // Shared multiplier operands
  accT       prod;
  accT       z1, z2;        // Integrator states
  accT       z1Shift, sumFull, sumShift, yShift;

  ////////////////////////////////////////////////////////////////////////////
  // Shared multiplier and fixed-point scaling

  assign prod = mA * mB;  // Combinational 18x18

  assign z1Shift  = z1 >>> COEF_FRAC;
  // Input minus damping product minus low-pass feedback
  assign sumFull  = (accT'(xLatch) <<< SAMPLE_SHIFT) - prod - z2;
  assign sumShift = sumFull >>> COEF_FRAC;
  assign yShift   = z2 >>> SAMPLE_SHIFT;

  assign yOut = yShift[17:0];
  assign busy = (state != IDLE);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer and integrators

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= IDLE;
      done  <= 1'b0;
      z1    <= '0;
      z2    <= '0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        IDLE:
        begin
          if (start)
            state <= DAMP;
        end
        DAMP:
          state <= INTEG1;      // prod is q * z1 here
        INTEG1:
        begin
          z1    <= z1 + prod;   // Band integrator, f * sum
          state <= INTEG2;
        end
        INTEG2:
        begin
          z2    <= z2 + prod;   // Low integrator, f * old z1
          done  <= 1'b1;
          state <= IDLE;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // Operand steering, one product per state
  always_ff @(posedge clk)
  begin
    if (state == IDLE && start)
    begin
      xLatch <= sampleIn;
      mA     <= z1Shift[17:0];
      mB     <= q;
    end
    else if (state == DAMP)
    begin
      mA <= f;
      mB <= sumShift[17:0];
    end
    else if (state == INTEG1)
    begin
      mA <= f;
      mB <= z1Shift[17:0];      // z1 before this edge's update
    end
  end

endmodule

`default_nettype wire

// ==== verilog/svfMixer.sv ====
`timescale 1ns/1ns
`default_nettype none

module svfMixer import svfPkg::*;
(
  input  logic   clk,
  input  logic   rstN,
  input  logic   inValid,    // Core done strobe
  input  sampleT yA,
  input  sampleT yB,
  input  coefT   gainA,
  input  coefT   gainB,
  output sampleT outSample,
  output logic   outValid
);

  accT                prodA, prodB;
  logic signed [36:0] mixSum;     // One guard bit over the products
  logic signed [36:0] mixShift;
  sampleT             mixSat;

  assign prodA    = gainA * yA;
  assign prodB    = gainB * yB;
  assign mixSum   = prodA + prodB;
  assign mixShift = mixSum >>> COEF_FRAC;  // Truncating

  ////////////////////////////////////////////////////////////////////////////
  // Saturation to the sample range

  always_comb
  begin
    if (mixShift > SAMPLE_MAX)
      mixSat = SAMPLE_MAX;
    else if (mixShift < SAMPLE_MIN)
      mixSat = SAMPLE_MIN;
    else
      mixSat = mixShift[17:0];
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      outValid <= 1'b0;
    else
      outValid <= inValid;  // One cycle behind done
  end

  always_ff @(posedge clk)
  begin
    if (inValid)
      outSample <= mixSat;
  end

endmodule

`default_nettype wire

// ==== verilog/dualSvf.sv ====
`timescale 1ns/1ns
`default_nettype none

module dualSvf import svfPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  // AXI4-Lite register port
  input  logic       sAwvalid,
  output logic       sAwready,
  input  addrT       sAwaddr,
  input  logic       sWvalid,
  output logic       sWready,
  input  dataT       sWdata,
  output logic       sBvalid,
  input  logic       sBready,
  output logic [1:0] sBresp,
  input  logic       sArvalid,
  output logic       sArready,
  input  addrT       sAraddr,
  output logic       sRvalid,
  input  logic       sRready,
  output dataT       sRdata,
  output logic [1:0] sRresp,
  // Sample stream
  input  logic       sampleValid,
  input  sampleT     sampleIn,
  output logic       sampleReady,
  output sampleT     outSample,
  output logic       outValid
);

  coefT   fA, qA, fB, qB, gainA, gainB;
  sampleT yA, yB;
  logic   doneA;
  logic   accept;     // Sample taken this edge
  logic   inFlight;   // One sample inside the filters

  assign accept      = sampleValid && sampleReady;
  assign sampleReady = !inFlight;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      inFlight <= 1'b0;
    else if (accept)
      inFlight <= 1'b1;
    else if (outValid)
      inFlight <= 1'b0;   // Free again after the mixed result
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers, two voices and the mixer

  svfRegs regs0 (
    .clk, .rstN,
    .sAwvalid, .sAwready, .sAwaddr, .sWvalid, .sWready, .sWdata,
    .sBvalid, .sBready, .sBresp,
    .sArvalid, .sArready, .sAraddr, .sRvalid, .sRready, .sRdata, .sRresp,
    .outValid,
    .fA, .qA, .fB, .qB, .gainA, .gainB
  );

  svfCore coreA (
    .clk, .rstN, .start(accept), .sampleIn,
    .f(fA), .q(qA), .yOut(yA), .done(doneA), .busy()
  );

  // Same timing as coreA, its done and busy are for waveforms only
  svfCore coreB (
    .clk, .rstN, .start(accept), .sampleIn,
    .f(fB), .q(qB), .yOut(yB), .done(), .busy()
  );

  svfMixer mixer0 (
    .clk, .rstN, .inValid(doneA),
    .yA, .yB, .gainA, .gainB,
    .outSample, .outValid
  );

endmodule

`default_nettype wire

// ==== test/tbTasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// All tasks start and end 5 ns after a rising edge
// Handshakes are judged at the falling edge where every signal is stable

// AXI4-Lite write with AW and W offered together and B ready after a random delay
task automatic axiWrite(input addrT addr, input dataT data, output logic [1:0] resp);
  logic awDone, wDone;
  logic awNow, wNow;
  int   delay;
  awDone   = 1'b0;
  wDone    = 1'b0;
  sAwaddr  = addr;
  sWdata   = data;
  sAwvalid = 1'b1;
  sWvalid  = 1'b1;
  while (!(awDone && wDone))
  begin
    @(negedge clk);
    awNow = sAwvalid && sAwready;  // Taken at the coming edge
    wNow  = sWvalid && sWready;
    @(posedge clk);
    #5;
    if (awNow)
    begin
      sAwvalid = 1'b0;
      awDone   = 1'b1;
    end
    if (wNow)
    begin
      sWvalid = 1'b0;
      wDone   = 1'b1;
    end
  end
  delay = $urandom % 4;           // Response back-pressure
  repeat (delay)
  begin
    @(posedge clk);
    #5;
  end
  sBready = 1'b1;
  do @(negedge clk); while (!sBvalid);
  resp = sBresp;
  @(posedge clk);
  #5;
  sBready = 1'b0;
endtask

// AXI4-Lite read with a random R ready delay
task automatic axiRead(input addrT addr, output dataT data, output logic [1:0] resp);
  int delay;
  sAraddr  = addr;
  sArvalid = 1'b1;
  do @(negedge clk); while (!sArready);
  @(posedge clk);
  #5;
  sArvalid = 1'b0;
  delay    = $urandom % 4;
  repeat (delay)
  begin
    @(posedge clk);
    #5;
  end
  sRready = 1'b1;
  do @(negedge clk); while (!sRvalid);
  data = sRdata;
  resp = sRresp;
  @(posedge clk);
  #5;
  sRready = 1'b0;
endtask

// One sample in and one mixed sample out with valid held while the DUT is busy
task automatic sendSample(input sampleT x, output sampleT y, output int latency);
  int acceptCycle;
  sampleValid = 1'b1;
  sampleIn    = x;
  do @(negedge clk); while (!sampleReady);
  acceptCycle = cycleCount;       // Handshake cycle
  inFlightTb  = 1'b1;
  @(negedge clk);
  while (!outValid)
  begin
    if (sampleReady)
    begin
      protocolErrors++;
      $display("sampleReady rose while a sample was still in flight");
    end
    @(negedge clk);
  end
  y       = outSample;
  latency = cycleCount - acceptCycle;
  @(posedge clk);                 // Held valid is still refused here
  #5;
  inFlightTb  = 1'b0;
  sampleValid = 1'b0;
  sampleIn    = '0;
endtask

`endif

// ==== test/dualSvfTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dualSvfTb import svfPkg::*; ();

  logic       clk;
  logic       rstN;
  logic       sAwvalid, sAwready, sWvalid, sWready;
  addrT       sAwaddr, sAraddr;
  dataT       sWdata, sRdata;
  logic       sBvalid, sBready, sArvalid, sArready, sRvalid, sRready;
  logic [1:0] sBresp, sRresp;
  logic       sampleValid, sampleReady, outValid;
  sampleT     sampleIn, outSample;

  int         cycleCount = 0;
  int         cycleLimit = 0;    // Set once the record count is known
  int         checkCount = 0;
  int         valueErrors = 0;
  int         protocolErrors = 0;
  logic       inFlightTb = 1'b0; // A sample is between handshake and result

  string      kindQ[$];          // Golden records
  dataT       aQ[$];             // Address or input sample
  dataT       bQ[$];             // Data or expected output
  string      nameQ[$];

  dualSvf dut0 (
    .clk, .rstN,
    .sAwvalid, .sAwready, .sAwaddr, .sWvalid, .sWready, .sWdata,
    .sBvalid, .sBready, .sBresp,
    .sArvalid, .sArready, .sAraddr, .sRvalid, .sRready, .sRdata, .sRresp,
    .sampleValid, .sampleIn, .sampleReady, .outSample, .outValid
  );

  `include "tbTasks.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Clock, cycle count and timeout

  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit)
    begin
      $display("Run timed out after %0d cycles", cycleCount);
      $display(">>> FAIL");
      $finish;
    end
  end

  // No result may appear unless a sample was sent
  always @(negedge clk)
  begin
    if (rstN && outValid && !inFlightTb)
    begin
      protocolErrors++;
      $display("outValid pulsed with no sample in flight at cycle %0d", cycleCount);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Golden file reader

  task automatic loadGolden();
    int    fd;
    int    n;
    string tok, name, rest;
    dataT  a, b;
    fd = $fopen("test/dualSvfGolden.txt", "r");
    if (fd == 0)
    begin
      protocolErrors++;
      $display("Cannot open the golden file");
    end
    else
    begin
      while (!$feof(fd))
      begin
        n = $fscanf(fd, "%s", tok);
        if (n != 1)
          break;
        b = '0;
        if (tok.substr(0, 0) == "#")
          n = $fgets(rest, fd);     // Skip comment line
        else if (tok == "E")
        begin
          n = $fscanf(fd, "%h %s", a, name);
          kindQ.push_back(tok);
          aQ.push_back(a);
          bQ.push_back(b);
          nameQ.push_back(name);
        end
        else
        begin
          n = $fscanf(fd, "%h %h %s", a, b, name);
          kindQ.push_back(tok);
          aQ.push_back(a);
          bQ.push_back(b);
          nameQ.push_back(name);
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checks

  initial
  begin
    logic [1:0] resp;
    dataT       rdData;
    sampleT     yMix;
    int         latency;
    int         gap;
    void'($urandom(32'h8ab8));
    clk = 1'b0;
    rstN = 1'b0;
    sAwvalid = 1'b0;
    sAwaddr = '0;
    sWvalid = 1'b0;
    sWdata = '0;
    sBready = 1'b0;
    sArvalid = 1'b0;
    sAraddr = '0;
    sRready = 1'b0;
    sampleValid = 1'b0;
    sampleIn = '0;
    loadGolden();
    cycleLimit = kindQ.size() * 20 + 200;
    repeat (8) @(posedge clk);
    #5;
    rstN = 1'b1;
    @(negedge clk);
    checkCount++;
    if (!sampleReady || outValid)
    begin
      protocolErrors++;
      $display("Stream handshake not idle after reset");
    end
    @(posedge clk);
    #5;
    for (int i = 0; i < kindQ.size(); i++)
    begin
      checkCount++;
      case (kindQ[i])
        "W":
        begin
          axiWrite(aQ[i][7:0], bQ[i], resp);
          if (resp !== RESP_OKAY)
          begin
            valueErrors++;
            $display("FAILED %s expected %h actual %h", nameQ[i], RESP_OKAY, resp);
          end
        end
        "E":
        begin
          axiWrite(aQ[i][7:0], 32'h0001_5a5a, resp);  // Must be dropped
          if (resp !== RESP_SLVERR)
          begin
            valueErrors++;
            $display("FAILED %s expected %h actual %h", nameQ[i], RESP_SLVERR, resp);
          end
        end
        "R":
        begin
          axiRead(aQ[i][7:0], rdData, resp);
          if (rdData !== bQ[i] || resp !== RESP_OKAY)
          begin
            valueErrors++;
            $display("FAILED %s expected %h actual %h resp %b", nameQ[i], bQ[i], rdData, resp);
          end
        end
        "S":
        begin
          gap = $urandom % 8;       // Idle cycles before the sample
          repeat (gap)
          begin
            @(posedge clk);
            #5;
          end
          sendSample(aQ[i][17:0], yMix, latency);
          if (yMix !== bQ[i][17:0])
          begin
            valueErrors++;
            $display("FAILED %s expected %h actual %h", nameQ[i], bQ[i][17:0], yMix);
          end
          if (latency != 5)
          begin
            valueErrors++;
            $display("FAILED %s latency expected 5 actual %0d", nameQ[i], latency);
          end
        end
        default:
        begin
          protocolErrors++;
          $display("Unknown golden record kind %s", kindQ[i]);
        end
      endcase
    end
    $display("Records %0d, checks %0d, value errors %0d, protocol errors %0d",
             kindQ.size(), checkCount, valueErrors, protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+test
verilog/svfPkg.sv
verilog/svfRegs.sv
verilog/svfCore.sv
verilog/svfMixer.sv
verilog/dualSvf.sv
test/dualSvfTb.sv

// ==== Bender.yml ====
package:
  name: dual_svf

sources:
  - files:
      - verilog/svfPkg.sv
      - verilog/svfRegs.sv
      - verilog/svfCore.sv
      - verilog/svfMixer.sv
      - verilog/dualSvf.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/dualSvfTb.sv

// ==== test/dualSvfGolden.txt ====
# W addr data name | R addr expected name | E addr name (expects SLVERR)
# S sampleIn expectedOut name, samples are 18-bit hex, all fields hex
R 00 00000000 rstFa
R 04 00000000 rstQa
R 08 00000000 rstFb
R 0c 00000000 rstQb
R 10 00000000 rstGainA
R 14 00000000 rstGainB
R 18 00000000 rstStatus
W 08 abc20000 fbUpperBits
R 08 fffe0000 fbSignExt
W 14 0003ffff gainBMinus
R 14 ffffffff gainBSignExt
E 18 statusWrite
R 18 00000000 statusKept
E 1c holeWrite
E 40 holeWriteHigh
R 14 ffffffff gainBKept
W 08 00000000 fbClear
W 14 00000000 gainBClear
W 00 00010000 faSet
W 04 00010000 qaSet
W 10 00010000 gainASet
R 00 00010000 faRead
S 003e8 00000 impulse0
S 00000 0007d impulse1
S 00000 000da impulse2
S 00000 00101 impulse3
S 00000 000e8 impulse4
W 08 00018000 fbSet
W 0c 00018000 qbSet
W 14 00010000 gainBSet
S 0ea60 00094 dual0
S 0ea60 05f53 dual1
S 0ea60 0f0d9 dual2
W 10 00020000 gainAMinusOne
W 14 00020000 gainBMinusOne
R 10 fffe0000 gainAMinusRead
S 0ea60 20000 dualSat
R 18 00000009 statusCount
